/* design/ibuf_pkg.sv */
// shared widths and types for the issue front; warp index is 2 bits so at most 4 warps fit
`default_nettype none

package ibuf_pkg;

    localparam int WARP_ID_W   = 2;
    localparam int NUM_THREADS = 4;
    localparam int PERF_CTR_W  = 16;

    typedef logic [WARP_ID_W-1:0]   warp_id_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [31:0]            pc_t;
    typedef logic [31:0]            instr_word_t;
    typedef logic [4:0]             reg_id_t;
    typedef logic [6:0]             opcode_t;
    typedef logic [PERF_CTR_W-1:0]  perf_ctr_t;

    // operation class, picks the functional unit behind the issue port
    typedef enum logic [1:0] {
        EX_ALU    = 2'd0,
        EX_LSU    = 2'd1,
        EX_BRANCH = 2'd2,
        EX_SFU    = 2'd3
    } ex_type_t;

    // major opcodes, instruction bits 6 to 0
    localparam opcode_t OPC_LOAD    = 7'b0000011;
    localparam opcode_t OPC_STORE   = 7'b0100011;
    localparam opcode_t OPC_BRANCH  = 7'b1100011;
    localparam opcode_t OPC_JAL     = 7'b1101111;
    localparam opcode_t OPC_JALR    = 7'b1100111;
    localparam opcode_t OPC_CUSTOM0 = 7'b0001011;

    typedef struct packed {
        warp_id_t    wid;
        tmask_t      tmask;
        pc_t         pc;
        instr_word_t instr;
    } fetch_req_t;

    typedef struct packed {
        warp_id_t wid;
        tmask_t   tmask;
        pc_t      pc;
        ex_type_t ex_type;
        logic     wb;
        reg_id_t  rd;
        reg_id_t  rs1;
        reg_id_t  rs2;
    } decoded_instr_t;

endpackage

`default_nettype wire

/* design/decode_stage.sv */
// four-phase fetch receiver; fetch_data must hold steady while fetch_req is high
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fetch_req,
    input  ibuf_pkg::fetch_req_t       fetch_data,
    output logic                       fetch_ack,
    output logic                       dec_valid,
    output ibuf_pkg::decoded_instr_t   dec_data,
    input  logic                       dec_ready
);
    import ibuf_pkg::*;

    // WAIT_DROP means a request is pending but the output register has not drained yet
    typedef enum logic [1:0] {
        IDLE,
        ACKED,
        WAIT_DROP
    } fetch_state_t;

    fetch_state_t   state;
    fetch_state_t   state_next;
    decoded_instr_t decoded;
    opcode_t        opcode;
    logic           can_capture;
    logic           capture;

    // the output register is free when empty or when it hands over at this edge
    assign can_capture = !dec_valid || dec_ready;
    assign capture     = fetch_req && can_capture && (state != ACKED);
    assign fetch_ack   = (state == ACKED);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (fetch_req) begin
                    state_next = can_capture ? ACKED : WAIT_DROP;
                end
            end
            WAIT_DROP: begin
                if (!fetch_req) begin
                    state_next = IDLE;
                end else if (can_capture) begin
                    state_next = ACKED;
                end
            end
            ACKED: begin
                // ack drops on the first edge that sees the request gone
                if (!fetch_req) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // field decode of the raw word
    always_comb begin
        opcode        = fetch_data.instr[6:0];
        decoded.wid   = fetch_data.wid;
        decoded.tmask = fetch_data.tmask;
        decoded.pc    = fetch_data.pc;
        decoded.rd    = fetch_data.instr[11:7];
        decoded.rs1   = fetch_data.instr[19:15];
        decoded.rs2   = fetch_data.instr[24:20];
        case (opcode)
            OPC_LOAD, OPC_STORE:             decoded.ex_type = EX_LSU;
            OPC_BRANCH, OPC_JAL, OPC_JALR:   decoded.ex_type = EX_BRANCH;
            OPC_CUSTOM0:                     decoded.ex_type = EX_SFU;
            default:                         decoded.ex_type = EX_ALU;
        endcase
        // stores and conditional branches never write, and neither does x0
        decoded.wb = (opcode != OPC_STORE) && (opcode != OPC_BRANCH)
                     && (decoded.rd != reg_id_t'(0));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            dec_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (capture) begin
                dec_valid <= 1'b1;
            end else if (dec_ready) begin
                dec_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dec_data <= decoded;
        end
    end

    // the fetch unit keeps its payload steady until it sees the ack
    a_fetch_stable: assert property (
        @(posedge clk) disable iff (reset)
        (fetch_req && !fetch_ack) ##1 fetch_req |-> $stable(fetch_data)
    ) else $error("fetch_data changed while fetch_req was pending");

endmodule

`default_nettype wire

/* design/instr_fifo.sv */
// elastic FIFO with registered output, so a write reaches valid_out one cycle later
`timescale 1ns/10ps
`default_nettype none

module instr_fifo #(
    parameter int DEPTH  = 4,
    parameter int DATA_W = 56
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_in,
    input  logic [DATA_W-1:0] data_in,
    output logic              ready_in,
    output logic              valid_out,
    output logic [DATA_W-1:0] data_out,
    input  logic              ready_out
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0]  ptr_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [DATA_W-1:0] word_t;

    word_t mem [DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    // count covers the storage entries plus the output register
    cnt_t  count;
    cnt_t  mem_count;
    logic  push;
    logic  pop;
    logic  load;

    assign ready_in  = (count < cnt_t'(DEPTH));
    assign push      = valid_in && ready_in;
    assign pop       = valid_out && ready_out;
    assign mem_count = count - cnt_t'(valid_out);
    // refill the output stage whenever it is empty or being drained
    assign load      = (mem_count != cnt_t'(0)) && (!valid_out || ready_out);

    function automatic ptr_t ptr_inc(input ptr_t ptr);
        if (ptr == ptr_t'(DEPTH - 1)) begin
            return ptr_t'(0);
        end
        return ptr + ptr_t'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= ptr_t'(0);
            rd_ptr    <= ptr_t'(0);
            count     <= cnt_t'(0);
            valid_out <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (load) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_t'(push) - cnt_t'(pop);
            if (load) begin
                valid_out <= 1'b1;
            end else if (pop) begin
                valid_out <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
        if (load) begin
            data_out <= mem[rd_ptr];
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset) count <= cnt_t'(DEPTH)
    ) else $error("FIFO count above depth");

    // an entry on the output must still be accounted for in the count
    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset) valid_out |-> (count != cnt_t'(0))
    ) else $error("FIFO presents data with a zero count");

endmodule

`default_nettype wire

/* design/instr_buffer.sv */
// per-warp instruction buffer; a full warp only blocks decode when decode holds that warp
`timescale 1ns/10ps
`default_nettype none

module instr_buffer #(
    parameter int NUM_WARPS = 4,
    parameter int IBUF_SIZE = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dec_valid,
    input  ibuf_pkg::decoded_instr_t dec_data,
    output logic                     dec_ready,
    output logic                     buf_valid [NUM_WARPS],
    output ibuf_pkg::decoded_instr_t buf_data  [NUM_WARPS],
    input  logic                     buf_ready [NUM_WARPS],
    output ibuf_pkg::perf_ctr_t      perf_stalls
);
    import ibuf_pkg::*;

    localparam int DATA_W = $bits(decoded_instr_t);

    logic [NUM_WARPS-1:0] fifo_ready;
    logic                 wid_ok;
    logic                 stall;

    assign wid_ok = (int'(dec_data.wid) < NUM_WARPS);
    // ready comes straight from the target warp's FIFO
    assign dec_ready = wid_ok ? fifo_ready[dec_data.wid] : 1'b0;
    assign stall     = dec_valid && !dec_ready;

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp_fifo
        instr_fifo #(
            .DEPTH  (IBUF_SIZE),
            .DATA_W (DATA_W)
        ) u_fifo (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (dec_valid && (dec_data.wid == warp_id_t'(w))),
            .data_in   (dec_data),
            .ready_in  (fifo_ready[w]),
            .valid_out (buf_valid[w]),
            .data_out  (buf_data[w]),
            .ready_out (buf_ready[w])
        );
    end

    // cycles where decode has an instruction that its warp cannot take
    always_ff @(posedge clk) begin
        if (reset) begin
            perf_stalls <= perf_ctr_t'(0);
        end else if (stall) begin
            perf_stalls <= perf_stalls + perf_ctr_t'(1);
        end
    end

    a_wid_in_range: assert property (
        @(posedge clk) disable iff (reset) dec_valid |-> wid_ok
    ) else $error("decoded warp id %0d out of range", dec_data.wid);

endmodule

`default_nettype wire

/* design/issue_select.sv */
// round-robin issue arbiter, combinational from the FIFO heads to the issue port
`timescale 1ns/10ps
`default_nettype none

module issue_select #(
    parameter int NUM_WARPS = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     buf_valid [NUM_WARPS],
    input  ibuf_pkg::decoded_instr_t buf_data  [NUM_WARPS],
    output logic                     buf_ready [NUM_WARPS],
    output logic                     issue_valid,
    output ibuf_pkg::decoded_instr_t issue_data,
    input  logic                     issue_ready
);
    import ibuf_pkg::*;

    warp_id_t             rr_ptr;
    warp_id_t             grant;
    warp_id_t             grant_next;
    logic                 found;
    logic                 issue_fire;
    logic [NUM_WARPS-1:0] ready_vec;

    // scan from the pointer and take the first warp with a valid head
    always_comb begin
        int idx;
        found = 1'b0;
        grant = rr_ptr;
        for (int i = 0; i < NUM_WARPS; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_WARPS;
            if (!found && buf_valid[idx]) begin
                found = 1'b1;
                grant = warp_id_t'(idx);
            end
        end
    end

    assign issue_valid = found;
    assign issue_data  = buf_data[grant];
    assign issue_fire  = found && issue_ready;
    assign grant_next  = (int'(grant) == NUM_WARPS - 1) ? warp_id_t'(0) : grant + warp_id_t'(1);

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_ready
        assign ready_vec[w] = issue_fire && (grant == warp_id_t'(w));
        assign buf_ready[w] = ready_vec[w];
    end

    // the pointer moves just past the warp that issued
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= warp_id_t'(0);
        end else if (issue_fire) begin
            rr_ptr <= grant_next;
        end
    end

    a_ready_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(ready_vec)
    ) else $error("more than one warp FIFO popped in one cycle");

    // the head routed by the buffer must belong to the FIFO it came from
    a_wid_matches_grant: assert property (
        @(posedge clk) disable iff (reset) issue_fire |-> (issue_data.wid == grant)
    ) else $error("issued warp id %0d differs from granted FIFO %0d", issue_data.wid, grant);

endmodule

`default_nettype wire

/* design/issue_front.sv */
// issue front top; NUM_WARPS may not exceed 4 and IBUF_SIZE must be at least 2
`timescale 1ns/10ps
`default_nettype none

module issue_front #(
    parameter int NUM_WARPS = 4,
    parameter int IBUF_SIZE = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fetch_req,
    input  ibuf_pkg::fetch_req_t     fetch_data,
    output logic                     fetch_ack,
    output logic                     issue_valid,
    output ibuf_pkg::decoded_instr_t issue_data,
    input  logic                     issue_ready,
    output ibuf_pkg::perf_ctr_t      perf_stalls
);
    import ibuf_pkg::*;

    logic           dec_valid;
    decoded_instr_t dec_data;
    logic           dec_ready;

    logic           buf_valid [NUM_WARPS];
    decoded_instr_t buf_data  [NUM_WARPS];
    logic           buf_ready [NUM_WARPS];

    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_data (fetch_data),
        .fetch_ack  (fetch_ack),
        .dec_valid  (dec_valid),
        .dec_data   (dec_data),
        .dec_ready  (dec_ready)
    );

    instr_buffer #(
        .NUM_WARPS (NUM_WARPS),
        .IBUF_SIZE (IBUF_SIZE)
    ) u_ibuf (
        .clk         (clk),
        .reset       (reset),
        .dec_valid   (dec_valid),
        .dec_data    (dec_data),
        .dec_ready   (dec_ready),
        .buf_valid   (buf_valid),
        .buf_data    (buf_data),
        .buf_ready   (buf_ready),
        .perf_stalls (perf_stalls)
    );

    issue_select #(
        .NUM_WARPS (NUM_WARPS)
    ) u_select (
        .clk         (clk),
        .reset       (reset),
        .buf_valid   (buf_valid),
        .buf_data    (buf_data),
        .buf_ready   (buf_ready),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .issue_ready (issue_ready)
    );

endmodule

`default_nettype wire

/* tb/tb_issue_front.sv */
// default-parameter testbench; must run from the project root to find tb/issue_golden.txt
`timescale 1ns/10ps
`default_nettype none

module tb_issue_front;
    import ibuf_pkg::*;

    localparam int NUM_LINES   = 38;
    localparam int FIELDS      = 9;
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_MAX   = 5000;
    localparam int HOLD_CYCLES = 20;
    // line ranges of the three phases in the golden file
    localparam int BP_FIRST    = 24;
    localparam int BP_LAST     = 29;
    localparam int FAIR_FIRST  = 30;

    logic           clk;
    logic           reset;
    logic           fetch_req;
    fetch_req_t     fetch_data;
    logic           fetch_ack;
    logic           issue_valid;
    decoded_instr_t issue_data;
    logic           issue_ready;
    perf_ctr_t      perf_stalls;

    logic [31:0]    golden [NUM_LINES*FIELDS];
    decoded_instr_t exp_q [4][$];
    integer         seed = 32'h53de_92bf;
    // sink mode 0 drives random ready, 1 holds ready low and 2 holds it high
    int             sink_mode;
    logic           prev_fire;
    warp_id_t       prev_wid;
    perf_ctr_t      stall_base;

    issue_front DUT (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_data  (fetch_data),
        .fetch_ack   (fetch_ack),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .issue_ready (issue_ready),
        .perf_stalls (perf_stalls)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_decoded(input string name, input decoded_instr_t got,
                                 input decoded_instr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input perf_ctr_t got, input perf_ctr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR: %s got %h expected %h", name, got, exp));
        end
    endtask

    // raise the request for one golden line and queue what decode should make of it
    task automatic start_fetch(input int idx);
        int             b;
        decoded_instr_t exp;
        b = idx * FIELDS;
        exp.wid     = warp_id_t'(golden[b]);
        exp.tmask   = tmask_t'(golden[b+1]);
        exp.pc      = golden[b+2];
        exp.ex_type = ex_type_t'(golden[b+4][1:0]);
        exp.wb      = golden[b+5][0];
        exp.rd      = reg_id_t'(golden[b+6]);
        exp.rs1     = reg_id_t'(golden[b+7]);
        exp.rs2     = reg_id_t'(golden[b+8]);
        exp_q[exp.wid].push_back(exp);
        @(posedge clk);
        fetch_data.wid   <= warp_id_t'(golden[b]);
        fetch_data.tmask <= tmask_t'(golden[b+1]);
        fetch_data.pc    <= golden[b+2];
        fetch_data.instr <= golden[b+3];
        fetch_req        <= 1'b1;
    endtask

    task automatic wait_ack_level(input logic level);
        int n;
        n = 0;
        while (fetch_ack !== level) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_now($sformatf("timeout waiting for fetch_ack to become %0d", level));
            end
        end
    endtask

    task automatic finish_fetch();
        wait_ack_level(1'b1);
        fetch_req <= 1'b0;
        @(posedge clk);
        wait_ack_level(1'b0);
    endtask

    task automatic send_line(input int idx);
        start_fetch(idx);
        @(posedge clk);
        finish_fetch();
    endtask

    task automatic drain_all();
        int n;
        n = 0;
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0) begin
            @(posedge clk);
            n++;
            if (n > DRAIN_MAX) begin
                fail_now("timeout: expected instructions never came out of the issue port");
            end
        end
    endtask

    task automatic take_issue();
        warp_id_t w;
        int       others;
        w = issue_data.wid;
        if (exp_q[w].size() == 0) begin
            fail_now($sformatf("warp %0d issued an instruction that was never fetched", w));
        end
        others = 0;
        for (int i = 0; i < 4; i++) begin
            if (i != int'(w)) begin
                others += exp_q[i].size();
            end
        end
        if (sink_mode == 2 && prev_fire && prev_wid == w && others != 0) begin
            fail_now($sformatf("warp %0d granted twice in a row while others waited", w));
        end
        check_decoded("issue_data", issue_data, exp_q[w].pop_front());
        prev_wid = w;
    endtask

    // the issue sink samples the port at each edge and drives ready for the next cycle
    initial begin
        prev_fire = 1'b0;
        prev_wid  = '0;
        forever begin
            @(posedge clk);
            if (!reset) begin
                if (issue_valid && issue_ready) begin
                    take_issue();
                end
                prev_fire = issue_valid && issue_ready;
            end
            if (sink_mode == 0) begin
                issue_ready <= $random(seed) % 2;
            end else begin
                issue_ready <= (sink_mode == 2);
            end
        end
    end

    initial begin
        reset       = 1'b1;
        fetch_req   = 1'b0;
        fetch_data  = '0;
        issue_ready = 1'b0;
        sink_mode   = 1;
        $readmemh("tb/issue_golden.txt", golden);
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        check_bit("fetch_ack", fetch_ack, 1'b0);
        check_bit("issue_valid", issue_valid, 1'b0);
        check_count("perf_stalls", perf_stalls, perf_ctr_t'(0));

        // all warps interleaved under random back-pressure
        sink_mode = 0;
        for (int i = 0; i < BP_FIRST; i++) begin
            send_line(i);
        end
        drain_all();

        // warp 0 overfills; the last request has to wait in front of decode
        sink_mode = 1;
        repeat (2) @(posedge clk);
        for (int i = BP_FIRST; i < BP_LAST; i++) begin
            send_line(i);
        end
        start_fetch(BP_LAST);
        stall_base = perf_stalls;
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            check_bit("fetch_ack", fetch_ack, 1'b0);
        end
        // decode stays blocked on each of those edges, so each one adds a stall
        check_count("perf_stalls increase", perf_stalls - stall_base, perf_ctr_t'(HOLD_CYCLES));
        sink_mode = 0;
        finish_fetch();
        drain_all();

        // load every warp, then release the port and watch the grants
        sink_mode = 1;
        repeat (2) @(posedge clk);
        for (int i = FAIR_FIRST; i < NUM_LINES; i++) begin
            send_line(i);
        end
        repeat (3) @(posedge clk);
        sink_mode = 2;
        drain_all();

        @(posedge clk);
        check_bit("issue_valid", issue_valid, 1'b0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/issue_golden.txt */
// wid tmask pc instr | expected ex_type wb rd rs1 rs2
// lines 0-23 interleaved, 24-29 warp 0 overfill, 30-37 fairness load
0 F 00001000 003100B3 0 1 01 02 03
1 F 00002000 00030283 1 1 05 06 00
2 7 00003000 00838223 1 0 04 07 08
3 3 00004000 00A48163 2 0 02 09 0A
0 F 00001004 000000EF 2 1 01 00 00
1 1 00002004 00008067 2 0 00 01 00
2 F 00003004 00C5850B 3 1 0A 0B 0C
3 8 00004004 00000013 0 0 00 00 00
0 5 00001008 00000FB7 0 1 1F 00 00
1 F 00002008 016A8A33 0 1 14 15 16
2 A 00003008 403100B3 0 1 01 02 03
3 F 00004008 00018003 1 0 00 03 00
0 F 0000100C 0020800B 3 0 00 01 02
0 C 00001010 00030283 1 1 05 06 00
1 F 0000200C 00838223 1 0 04 07 08
2 F 0000300C 00A48163 2 0 02 09 0A
3 6 0000400C 000000EF 2 1 01 00 00
3 F 00004010 00C5850B 3 1 0A 0B 0C
2 1 00003010 00008067 2 0 00 01 00
1 F 00002010 00000013 0 0 00 00 00
0 F 00001014 016A8A33 0 1 14 15 16
1 9 00002014 00000FB7 0 1 1F 00 00
2 F 00003014 0020800B 3 0 00 01 02
3 F 00004014 00018003 1 0 00 03 00
0 F 00001018 003100B3 0 1 01 02 03
0 F 0000101C 00030283 1 1 05 06 00
0 F 00001020 00838223 1 0 04 07 08
0 F 00001024 00A48163 2 0 02 09 0A
0 F 00001028 00C5850B 3 1 0A 0B 0C
0 F 0000102C 000000EF 2 1 01 00 00
3 F 00004018 016A8A33 0 1 14 15 16
3 F 0000401C 00000013 0 0 00 00 00
2 F 00003018 00000FB7 0 1 1F 00 00
2 F 0000301C 00018003 1 0 00 03 00
1 F 00002018 0020800B 3 0 00 01 02
1 F 0000201C 00008067 2 0 00 01 00
0 F 00001030 403100B3 0 1 01 02 03
0 F 00001034 00838223 1 0 04 07 08

/* filelist.f */
design/ibuf_pkg.sv
design/decode_stage.sv
design/instr_fifo.sv
design/instr_buffer.sv
design/issue_select.sv
design/issue_front.sv
tb/tb_issue_front.sv
